// File: common/pipePkg.sv
`default_nettype none

package pipePkg;

    // Instruction address, one word per step.
    typedef logic [11:0] pcT;

    // Opcode in bits 15:13, branch target in bits 11:0.
    typedef logic [15:0] instrT;

    // Short cycle counts for multicycle units.
    typedef logic [3:0] cycT;

    typedef enum logic [2:0] {
        OP_ALU = 3'd0, // Moves through the pipe untouched.
        OP_MUL = 3'd1, // Holds Execute for MUL_CYCLES.
        OP_LD  = 3'd2, // Waits in Memory on the data memory.
        OP_BR  = 3'd3, // Always taken, target in the low bits.
        OP_EXC = 3'd4  // Traps in Memory.
    } opT;

    typedef enum logic [1:0] {
        HZ_RUN      = 2'd0, // No stale fetch outstanding.
        HZ_EXC_WAIT = 2'd1, // Exception redirect waiting on an old fetch.
        HZ_BR_WAIT  = 2'd2  // Branch redirect waiting on an old fetch.
    } hazStateT;

    localparam pcT RESET_PC = 12'h000;
    localparam pcT EXC_VECTOR = 12'h800;
    localparam cycT MUL_CYCLES = 4'd3;

    // The opcode field sits in the top bits of every instruction.
    localparam int OP_MSB = 15;
    localparam int OP_LSB = 13;

endpackage

`default_nettype wire

// File: src/busyTimer.sv
`timescale 1ns/1ps
`default_nettype none

module busyTimer (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  pipePkg::cycT count,
    output logic busy
);
    import pipePkg::*;

    cycT remain;
    cycT loaded;
    cycT busyRun;
    logic load;

    // A start only counts when the timer is idle and has work to do.
    assign load = start && (remain == '0) && (count != '0);
    assign busy = load || (remain != '0); // Busy already in the start cycle.

    always_ff @(posedge clk) begin
        if (reset) begin
            remain <= '0;
        end else if (load) begin
            remain <= count - cycT'(1); // The start cycle is the first one.
        end else if (remain != '0) begin
            remain <= remain - cycT'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            loaded <= count;
        end
    end

    // Number of busy cycles seen since the last start.
    always_ff @(posedge clk) begin
        if (reset) begin
            busyRun <= '0;
        end else if (load) begin
            busyRun <= cycT'(1);
        end else if (busy) begin
            busyRun <= busyRun + cycT'(1);
        end else begin
            busyRun <= '0;
        end
    end

    // The busy run never lasts longer than the count that started it.
    busyBounded: assert property (@(posedge clk) disable iff (reset)
        (busyRun != '0) |-> (busyRun <= loaded));

endmodule

`default_nettype wire

// File: src/stageReg.sv
`timescale 1ns/1ps
`default_nettype none

module stageReg (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic flush,
    input  logic inValid,
    input  pipePkg::pcT inPc,
    input  pipePkg::instrT inInstr,
    output logic outValid,
    output pipePkg::pcT outPc,
    output pipePkg::instrT outInstr
);

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (flush) begin
            outValid <= 1'b0; // A bubble enters this stage.
        end else if (!stall) begin
            outValid <= inValid;
        end
    end

    // Payload follows the input whenever the stage moves.
    always_ff @(posedge clk) begin
        if (!stall) begin
            outPc <= inPc;
            outInstr <= inInstr;
        end
    end

endmodule

`default_nettype wire

// File: src/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
    input  logic clk,
    input  logic reset,
    input  logic stallF,
    input  logic redirect,
    input  logic dropFetch,
    input  pipePkg::pcT redirectPc,
    input  logic imemValid,
    input  pipePkg::instrT imemData,
    output logic imemReq,
    output pipePkg::pcT imemAddr,
    output logic fetchPending,
    output logic fetchValid,
    output pipePkg::pcT fetchPc,
    output pipePkg::instrT fetchInstr
);
    import pipePkg::*;

    pcT pc;
    pcT reqPc;
    logic armed;
    logic accept;
    logic heldValid;
    pcT heldPc;
    instrT heldInstr;

    assign accept = imemValid && !dropFetch;
    assign imemReq = armed && !fetchPending && !stallF && !redirect; // One in flight.
    assign imemAddr = pc;
    assign fetchValid = heldValid || accept;
    assign fetchPc = heldValid ? heldPc : reqPc;
    assign fetchInstr = heldValid ? heldInstr : imemData;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
            armed <= 1'b0;
            fetchPending <= 1'b0;
            heldValid <= 1'b0;
        end else begin
            armed <= 1'b1; // First request goes out one cycle after reset.
            if (redirect) begin
                pc <= redirectPc; // Any answer still due is dropped later.
            end else if (imemReq) begin
                pc <= pc + 1'b1;
            end
            if (imemReq) begin
                fetchPending <= 1'b1;
            end else if (imemValid) begin
                fetchPending <= 1'b0;
            end
            if (redirect) begin
                heldValid <= 1'b0;
            end else if (accept && stallF) begin
                heldValid <= 1'b1; // Decode is frozen, park the word here.
            end else if (!stallF) begin
                heldValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imemReq) begin
            reqPc <= pc;
        end
        if (accept && stallF) begin
            heldPc <= reqPc;
            heldInstr <= imemData;
        end
    end

    // A new request waits until the previous one has been answered.
    singleOutstanding: assert property (@(posedge clk) disable iff (reset)
        imemReq |=> (!imemReq until imemValid));

endmodule

`default_nettype wire

// File: src/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit (
    input  logic clk,
    input  logic reset,
    input  logic issueValid,
    input  pipePkg::instrT issueInstr,
    input  logic stallI,
    input  logic exValid,
    input  pipePkg::instrT exInstr,
    input  logic memValid,
    input  pipePkg::instrT memInstr,
    input  logic dmemReady,
    output logic branchTaken,
    output logic mulBusy,
    output logic excpM,
    output logic ldWait,
    output pipePkg::pcT redirectPc
);
    import pipePkg::*;

    opT issueOp;
    opT exOp;
    opT memOp;
    logic exFresh;
    logic exIsMul;
    logic timerBusy;

    assign issueOp = opT'(issueInstr[OP_MSB:OP_LSB]);
    assign exOp = opT'(exInstr[OP_MSB:OP_LSB]);
    assign memOp = opT'(memInstr[OP_MSB:OP_LSB]);

    assign branchTaken = issueValid && (issueOp == OP_BR) && !stallI;
    assign excpM = memValid && (memOp == OP_EXC);
    assign ldWait = memValid && (memOp == OP_LD) && !dmemReady;
    assign exIsMul = exValid && (exOp == OP_MUL);

    // Issue and Execute always hold together, so stallI says Execute held too.
    always_ff @(posedge clk) begin
        if (reset) begin
            exFresh <= 1'b0;
        end else begin
            exFresh <= !stallI;
        end
    end

    busyTimer mulTimer (
        .clk(clk),
        .reset(reset),
        .start(exIsMul && exFresh),
        .count(MUL_CYCLES),
        .busy(timerBusy)
    );

    assign mulBusy = timerBusy && exIsMul; // A flushed multiply stops stalling.

    // Exception wins over a branch in the same cycle.
    assign redirectPc = excpM ? EXC_VECTOR : pcT'(issueInstr[11:0]);

endmodule

`default_nettype wire

// File: hazard/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  logic clk,
    input  logic reset,
    input  logic fetchPending,
    input  logic imemValid,
    input  logic ldWait,
    input  logic mulBusy,
    input  logic branchTaken,
    input  logic excpM,
    output logic stallF,
    output logic redirect,
    output logic dropFetch,
    output logic stallD,
    output logic flushD,
    output logic stallI,
    output logic flushI,
    output logic stallE,
    output logic flushE,
    output logic stallM,
    output logic flushM,
    output logic flushW
);
    import pipePkg::*;

    hazStateT state;
    hazStateT stateNext;
    logic fetchWait;

    // A request is out and its answer has not shown up yet.
    assign fetchWait = fetchPending && !imemValid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= HZ_RUN;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stallF = 1'b0;
        redirect = 1'b0;
        dropFetch = 1'b0;
        stallD = 1'b0;
        flushD = 1'b0;
        stallI = 1'b0;
        flushI = 1'b0;
        stallE = 1'b0;
        flushE = 1'b0;
        stallM = 1'b0;
        flushM = 1'b0;
        flushW = 1'b0;
        stateNext = state;

        if (excpM) begin
            flushD = 1'b1;
            flushI = 1'b1;
            flushE = 1'b1;
            flushM = 1'b1;
            flushW = 1'b1; // The trapping instruction itself must not retire.
            redirect = 1'b1;
            if (fetchWait) begin
                stallF = 1'b1;
                stateNext = HZ_EXC_WAIT; // Its answer belongs to the old path.
            end
        end else if (ldWait) begin
            stallF = 1'b1;
            stallD = 1'b1;
            stallI = 1'b1;
            stallE = 1'b1;
            stallM = 1'b1;
            flushW = 1'b1; // Bubble into writeback while the load sits.
        end else if (mulBusy) begin
            stallF = 1'b1;
            stallD = 1'b1;
            stallI = 1'b1;
            stallE = 1'b1;
            flushM = 1'b1;
        end else if (branchTaken) begin
            flushD = 1'b1; // Squash the two younger slots behind the branch.
            flushI = 1'b1;
            redirect = 1'b1;
            if (fetchWait) begin
                stallF = 1'b1;
                stateNext = HZ_BR_WAIT;
            end
        end else if (fetchWait) begin
            stallF = 1'b1;
            flushD = 1'b1;
        end

        // First answer after a late redirect is from the wrong path.
        if ((state != HZ_RUN) && fetchPending && imemValid) begin
            dropFetch = 1'b1;
            stateNext = HZ_RUN;
        end
    end

    noStallAndFlush: assert property (@(posedge clk) disable iff (reset)
        !((stallD && flushD) || (stallI && flushI) || (stallE && flushE) || (stallM && flushM)));

    // A wait state always has a stale fetch outstanding that it can discard.
    waitHasFetch: assert property (@(posedge clk) disable iff (reset)
        (state != HZ_RUN) |-> fetchPending);

endmodule

`default_nettype wire

// File: src/pipeCtrlTop.sv
`timescale 1ns/1ps
`default_nettype none

module pipeCtrlTop (
    input  logic clk,
    input  logic reset,
    output logic imemReq,
    output pipePkg::pcT imemAddr,
    input  logic imemValid,
    input  pipePkg::instrT imemData,
    input  logic dmemReady,
    output logic retireValid,
    output pipePkg::pcT retirePc
);
    import pipePkg::*;

    logic stallF, redirect, dropFetch;
    logic stallD, flushD, stallI, flushI;
    logic stallE, flushE, stallM, flushM, flushW;
    logic fetchPending, branchTaken, mulBusy, excpM, ldWait;
    pcT redirectPc;
    logic fetchValid, decValid, issValid, exValid, memValid;
    pcT fetchPc, decPc, issPc, exPc, memPc;
    instrT fetchInstr, decInstr, issInstr, exInstr, memInstr;

    fetchUnit fetch (
        .clk(clk), .reset(reset), .stallF(stallF), .redirect(redirect),
        .dropFetch(dropFetch), .redirectPc(redirectPc), .imemValid(imemValid),
        .imemData(imemData), .imemReq(imemReq), .imemAddr(imemAddr),
        .fetchPending(fetchPending), .fetchValid(fetchValid), .fetchPc(fetchPc),
        .fetchInstr(fetchInstr)
    );

    stageReg decodeReg (.clk(clk), .reset(reset), .stall(stallD), .flush(flushD),
        .inValid(fetchValid), .inPc(fetchPc), .inInstr(fetchInstr),
        .outValid(decValid), .outPc(decPc), .outInstr(decInstr));

    stageReg issueReg (.clk(clk), .reset(reset), .stall(stallI), .flush(flushI),
        .inValid(decValid), .inPc(decPc), .inInstr(decInstr),
        .outValid(issValid), .outPc(issPc), .outInstr(issInstr));

    stageReg executeReg (.clk(clk), .reset(reset), .stall(stallE), .flush(flushE),
        .inValid(issValid), .inPc(issPc), .inInstr(issInstr),
        .outValid(exValid), .outPc(exPc), .outInstr(exInstr));

    stageReg memoryReg (.clk(clk), .reset(reset), .stall(stallM), .flush(flushM),
        .inValid(exValid), .inPc(exPc), .inInstr(exInstr),
        .outValid(memValid), .outPc(memPc), .outInstr(memInstr));

    // Writeback never holds; each valid entry retires for exactly one cycle.
    stageReg writebackReg (.clk(clk), .reset(reset), .stall(1'b0), .flush(flushW),
        .inValid(memValid), .inPc(memPc), .inInstr(memInstr),
        .outValid(retireValid), .outPc(retirePc), .outInstr());

    execUnit exec (
        .clk(clk), .reset(reset), .issueValid(issValid), .issueInstr(issInstr),
        .stallI(stallI), .exValid(exValid), .exInstr(exInstr), .memValid(memValid),
        .memInstr(memInstr), .dmemReady(dmemReady), .branchTaken(branchTaken),
        .mulBusy(mulBusy), .excpM(excpM), .ldWait(ldWait), .redirectPc(redirectPc)
    );

    hazardUnit hazard (
        .clk(clk), .reset(reset), .fetchPending(fetchPending), .imemValid(imemValid),
        .ldWait(ldWait), .mulBusy(mulBusy), .branchTaken(branchTaken), .excpM(excpM),
        .stallF(stallF), .redirect(redirect), .dropFetch(dropFetch),
        .stallD(stallD), .flushD(flushD), .stallI(stallI), .flushI(flushI),
        .stallE(stallE), .flushE(flushE), .stallM(stallM), .flushM(flushM),
        .flushW(flushW)
    );

endmodule

`default_nettype wire

// File: verif/pipeCtrlTb.sv
`timescale 1ns/1ps
`default_nettype none

module pipeCtrlTb;
    import pipePkg::*;

    localparam int RETIRE_TIMEOUT = 200;

    logic clk;
    logic reset;
    logic imemReq;
    pcT imemAddr;
    logic imemValid;
    instrT imemData;
    logic dmemReady;
    logic retireValid;
    pcT retirePc;
    logic loadInMem;

    instrT imem [0:4095];
    pcT expPcs[$];
    logic [15:0] lfsr;
    bit randLat;
    int ldDelay;
    int ldCount;
    bit imemBusy;
    int imemLeft;
    pcT imemReqAddr;
    logic [1:0] imemDelay;
    int errCount;
    int testCount;
    int failedTests;

    pipeCtrlTop DUT (
        .clk(clk), .reset(reset), .imemReq(imemReq), .imemAddr(imemAddr),
        .imemValid(imemValid), .imemData(imemData), .dmemReady(dmemReady),
        .retireValid(retireValid), .retirePc(retirePc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // The data memory model looks at the Memory stage to see when a load is waiting.
    assign loadInMem = DUT.memValid && (opT'(DUT.memInstr[15:13]) == OP_LD);

    // Taps 16, 14, 13 and 11; the new bit enters at the bottom.
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic instrT makeInstr(input opT op, input pcT target);
        return {op, 1'b0, target};
    endfunction

    // Instruction memory answers each request after 0 to 3 extra cycles.
    always @(posedge clk) begin
        imemValid <= 1'b0;
        if (!reset && imemBusy && imemReq) begin
            $display("Error: imemReq asserted while a fetch was still outstanding");
            errCount++;
        end
        if (reset) begin
            imemBusy = 1'b0;
            imemLeft = 0;
        end else if (imemBusy) begin
            if (imemLeft == 0) begin
                imemValid <= 1'b1;
                imemData <= imem[imemReqAddr];
                imemBusy = 1'b0;
            end else begin
                imemLeft = imemLeft - 1;
            end
        end else if (imemReq) begin
            imemReqAddr = imemAddr;
            imemDelay = 2'd0;
            if (randLat) begin
                lfsr = lfsrNext(lfsr); // One step per bit of the delay.
                imemDelay[0] = lfsr[0];
                lfsr = lfsrNext(lfsr);
                imemDelay[1] = lfsr[0];
            end
            if (imemDelay == 2'd0) begin
                imemValid <= 1'b1;
                imemData <= imem[imemReqAddr];
            end else begin
                imemBusy = 1'b1;
                imemLeft = int'(imemDelay) - 1;
            end
        end
    end

    // Ready stays low while a load sits in Memory, for ldDelay cycles each.
    always @(posedge clk) begin
        if (reset || ldDelay == 0) begin
            dmemReady <= (ldDelay == 0);
            ldCount = 0;
        end else if (loadInMem && dmemReady) begin
            dmemReady <= 1'b0; // That load leaves at this edge.
            ldCount = 0;
        end else if (loadInMem) begin
            ldCount = ldCount + 1;
            if (ldCount >= ldDelay) begin
                dmemReady <= 1'b1;
            end
        end
    end

    task automatic checkPc(input pcT actual, input pcT want);
        if (actual !== want) begin
            $display("[FAIL] retirePc: got 0x%03h, expected 0x%03h", actual, want);
            errCount++;
        end
    endtask

    task automatic checkCount(input int actual, input int want);
        if (actual != want) begin
            $display("[FAIL] retireCount: got 0x%0h, expected 0x%0h", actual, want);
            errCount++;
        end
    endtask

    // Walks the program in order, the way the pipeline should retire it.
    task automatic buildExpected(input int n);
        pcT pc;
        opT op;
        int guard;
        pc = RESET_PC;
        guard = 0;
        expPcs.delete();
        while (expPcs.size() < n && guard < 10000) begin
            op = opT'(imem[pc][15:13]);
            guard++;
            if (op == OP_EXC) begin
                pc = EXC_VECTOR; // A trapping instruction never retires.
            end else begin
                expPcs.push_back(pc);
                pc = (op == OP_BR) ? pcT'(imem[pc][11:0]) : pc + 12'd1;
            end
        end
    endtask

    task automatic holdReset();
        @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        randLat = 1'b0;
        ldDelay = 0;
        for (int a = 0; a < 4096; a++) begin
            imem[a] = makeInstr(OP_ALU, pcT'(a)); // Low bits carry the address.
        end
    endtask

    task automatic waitRetire(output pcT pc, output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        pc = '0;
        while (!ok && cycles < RETIRE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            if (retireValid) begin
                ok = 1'b1;
                pc = retirePc;
            end
        end
    endtask

    task automatic runProgram(input string name, input int n);
        pcT got;
        bit ok;
        int retired;
        int errBefore;
        errBefore = errCount;
        retired = 0;
        testCount++;
        buildExpected(n);
        repeat (15) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < expPcs.size(); i++) begin
            waitRetire(got, ok);
            if (!ok) begin
                $display("Timeout: retirement %0d of %s did not arrive within %0d cycles",
                    i, name, RETIRE_TIMEOUT);
                errCount++;
                break;
            end
            retired++;
            checkPc(got, expPcs[i]);
        end
        checkCount(retired, expPcs.size());
        if (errCount != errBefore) begin
            failedTests++;
        end
        $display("Test %0d %s: %0d of %0d retired, %0d errors", testCount, name, retired,
            expPcs.size(), errCount - errBefore);
    endtask

    task automatic testStraightLine();
        holdReset();
        runProgram("straight line", 20);
    endtask

    task automatic testBranch();
        holdReset();
        imem[5] = makeInstr(OP_BR, 12'h040);
        runProgram("taken branch", 14);
    endtask

    task automatic testMultiply();
        holdReset();
        imem[2] = makeInstr(OP_MUL, 12'h002);
        imem[3] = makeInstr(OP_MUL, 12'h003); // Back to back with the first.
        imem[7] = makeInstr(OP_MUL, 12'h007);
        runProgram("multiply", 14);
    endtask

    task automatic testLoad();
        holdReset();
        ldDelay = 6;
        imem[3] = makeInstr(OP_LD, 12'h003);
        imem[4] = makeInstr(OP_LD, 12'h004);
        imem[9] = makeInstr(OP_LD, 12'h009);
        runProgram("load wait", 14);
    endtask

    task automatic testException();
        holdReset();
        imem[6] = makeInstr(OP_EXC, 12'h006);
        runProgram("exception", 12);
    endtask

    task automatic testRandomLatency();
        holdReset();
        randLat = 1'b1;
        ldDelay = 3;
        imem[12'h002] = makeInstr(OP_MUL, 12'h002);
        imem[12'h004] = makeInstr(OP_BR, 12'h030);
        imem[12'h013] = makeInstr(OP_MUL, 12'h013);
        imem[12'h031] = makeInstr(OP_LD, 12'h031);
        imem[12'h033] = makeInstr(OP_BR, 12'h060);
        imem[12'h061] = makeInstr(OP_BR, 12'h070);
        imem[12'h071] = makeInstr(OP_EXC, 12'h071);
        imem[12'h072] = makeInstr(OP_BR, 12'h020); // Younger than the trap.
        imem[12'h803] = makeInstr(OP_BR, 12'h010);
        runProgram("random latency", 60);
    endtask

    initial begin
        reset = 1'b1;
        imemValid = 1'b0;
        imemData = '0;
        dmemReady = 1'b1;
        lfsr = 16'd50;
        randLat = 1'b0;
        ldDelay = 0;
        errCount = 0;
        testCount = 0;
        failedTests = 0;
        testStraightLine();
        testBranch();
        testMultiply();
        testLoad();
        testException();
        testRandomLatency();
        $display("Tests run: %0d, tests failed: %0d, errors: %0d", testCount, failedTests,
            errCount);
        if (errCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: pipeCtrl.f
common/pipePkg.sv
src/busyTimer.sv
src/stageReg.sv
src/fetchUnit.sv
src/execUnit.sv
hazard/hazardUnit.sv
src/pipeCtrlTop.sv
verif/pipeCtrlTb.sv

// File: Bender.yml
package:
  name: pipeCtrl

sources:
  # Package first, then the leaf modules, then the top level.
  - common/pipePkg.sv
  - src/busyTimer.sv
  - src/stageReg.sv
  - src/fetchUnit.sv
  - src/execUnit.sv
  - hazard/hazardUnit.sv
  - src/pipeCtrlTop.sv

  # Testbench, top module pipeCtrlTb.
  - target: test
    files:
      - verif/pipeCtrlTb.sv
